//--- sources.f
src/sys_pkg.sv
src/sys_decode.sv
src/csr_alu.sv
src/csr_file.sv
src/sys_retire.sv
src/sys_unit_top.sv
verification/sys_unit_tb.sv

//--- Bender.yml
package:
  name: sys_unit

sources:
  - src/sys_pkg.sv
  - src/sys_decode.sv
  - src/csr_alu.sv
  - src/csr_file.sv
  - src/sys_retire.sv
  - src/sys_unit_top.sv
  - target: test
    files:
      - verification/sys_unit_tb.sv

//--- verification/sys_unit_tb.sv
`timescale 1ns/10ps

module sys_unit_tb;

  localparam int unsigned     xlen         = 32;
  localparam logic [xlen-1:0] vendor_id    = 32'h0000_0a11;
  localparam logic [xlen-1:0] arch_id      = 32'h0000_0017;
  localparam logic [xlen-1:0] mtvec_reset  = 32'h0000_0100;
  localparam int unsigned     random_insns = 3000;
  localparam int unsigned     drain_limit  = 4;

  logic               clock;
  logic               reset;
  logic               issue;
  sys_pkg::sys_insn_u insn;
  logic [xlen-1:0]    pc;
  logic [xlen-1:0]    rs1_data;
  logic               retire;
  logic               rd_wen;
  logic [4:0]         rd_addr;
  logic [xlen-1:0]    rd_data;
  logic               redirect;
  logic [xlen-1:0]    target_pc;
  logic               illegal;

  // Reference copy of the machine state
  sys_pkg::priv_e  model_priv;
  sys_pkg::priv_e  model_mpp;
  logic            model_mie;
  logic            model_mpie;
  logic [xlen-1:0] model_mcause;
  logic [xlen-1:0] model_mepc;
  logic [xlen-1:0] model_mtvec;

  // Expected retire of the instruction issued on the last falling edge
  logic            pending;
  logic            exp_rd_wen;
  logic [4:0]      exp_rd_addr;
  logic [xlen-1:0] exp_rd_data;
  logic            exp_redirect;
  logic [xlen-1:0] exp_target;
  logic            exp_illegal;

  integer seed;

  sys_unit_top #(
    .xlen(xlen), .vendor_id(vendor_id), .arch_id(arch_id), .mtvec_reset(mtvec_reset)
  ) dut (
    .clock(clock), .reset(reset), .issue(issue), .insn(insn), .pc(pc), .rs1_data(rs1_data),
    .retire(retire), .rd_wen(rd_wen), .rd_addr(rd_addr), .rd_data(rd_data),
    .redirect(redirect), .target_pc(target_pc), .illegal(illegal)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] want);
    if (got !== want) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, want));
    end
  endtask

  task automatic check_index(input string name, input logic [4:0] got, input logic [4:0] want);
    if (got !== want) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, want));
    end
  endtask

  function automatic logic [xlen-1:0] model_read(input logic [11:0] addr);
    logic [xlen-1:0] status;
    status = '0;
    status[sys_pkg::mstatus_mie] = model_mie;
    status[sys_pkg::mstatus_mpie] = model_mpie;
    status[sys_pkg::mstatus_mpp_lo +: 2] = model_mpp;
    case (addr)
      sys_pkg::csr_mstatus:   return status;
      sys_pkg::csr_mtvec:     return model_mtvec;
      sys_pkg::csr_mepc:      return model_mepc;
      sys_pkg::csr_mcause:    return model_mcause;
      sys_pkg::csr_mvendorid: return vendor_id;
      sys_pkg::csr_marchid:   return arch_id;
      default:                return '0;
    endcase
  endfunction

  task automatic model_write(input logic [11:0] addr, input logic [xlen-1:0] value);
    case (addr)
      sys_pkg::csr_mstatus: begin
        model_mie  = value[sys_pkg::mstatus_mie];
        model_mpie = value[sys_pkg::mstatus_mpie];
        if (value[sys_pkg::mstatus_mpp_lo +: 2] != 2'b10) begin // Encoding 2 names no mode
          model_mpp = sys_pkg::priv_e'(value[sys_pkg::mstatus_mpp_lo +: 2]);
        end
      end
      sys_pkg::csr_mtvec:  model_mtvec  = value;
      sys_pkg::csr_mepc:   model_mepc   = value;
      sys_pkg::csr_mcause: model_mcause = value;
      default: ;
    endcase
  endtask

  // Predicts the retire of one instruction and moves the model state past it
  task automatic predict(input sys_pkg::sys_insn_u w, input logic [xlen-1:0] p,
                         input logic [xlen-1:0] r);
    logic [2:0]      f3;
    logic [xlen-1:0] old;
    logic [xlen-1:0] operand;
    f3           = w.csr_form.funct3;
    exp_rd_wen   = 1'b0;
    exp_redirect = 1'b0;
    exp_illegal  = 1'b0;
    exp_rd_addr  = w.csr_form.rd;
    exp_rd_data  = '0;
    exp_target   = '0;
    if (w.csr_form.opcode != sys_pkg::opcode_system || f3 == 3'b100) begin
      exp_illegal = 1'b1;
    end else if (f3 == 3'b000) begin
      if (w.priv_form.funct12 == sys_pkg::funct12_ecall) begin
        exp_redirect = 1'b1;
        exp_target   = {model_mtvec[xlen-1:2], 2'b00};
        if (model_priv == sys_pkg::priv_machine) model_mcause = 11;
        else if (model_priv == sys_pkg::priv_supervisor) model_mcause = 9;
        else model_mcause = 8;
        model_mepc = p;
        model_mpie = model_mie;
        model_mie  = 1'b0;
        model_mpp  = model_priv;
        model_priv = sys_pkg::priv_machine;
      end else if (w.priv_form.funct12 == sys_pkg::funct12_mret) begin
        exp_redirect = 1'b1;
        exp_target   = model_mepc;
        model_priv   = model_mpp;
        model_mie    = model_mpie;
        model_mpie   = 1'b1;
        model_mpp    = sys_pkg::priv_user;
      end else begin
        exp_illegal = 1'b1;
      end
    end else begin
      old         = model_read(w.csr_form.csr);
      operand     = f3[2] ? xlen'(w.csr_form.src) : r;
      exp_rd_wen  = (w.csr_form.rd != 5'd0);
      exp_rd_data = old;
      case (f3[1:0])
        2'b01: model_write(w.csr_form.csr, operand);
        2'b10: if (w.csr_form.src != 5'd0) model_write(w.csr_form.csr, old | operand);
        default: if (w.csr_form.src != 5'd0) model_write(w.csr_form.csr, old & ~operand);
      endcase
    end
  endtask

  // Runs on a falling edge, where the outputs of the last rising edge are settled
  task automatic check_result;
    if (pending) begin
      if (retire !== 1'b1) abort_run("An issued instruction did not retire one cycle later");
      check_bit("rd_wen", rd_wen, exp_rd_wen);
      check_bit("redirect", redirect, exp_redirect);
      check_bit("illegal", illegal, exp_illegal);
      if (exp_rd_wen) begin
        check_index("rd_addr", rd_addr, exp_rd_addr);
        check_word("rd_data", rd_data, exp_rd_data);
      end
      if (exp_redirect) check_word("target_pc", target_pc, exp_target);
      pending = 1'b0;
    end else begin
      check_bit("retire", retire, 1'b0);
    end
  endtask

  task automatic idle_cycle;
    @(negedge clock);
    check_result();
    issue = 1'b0;
    insn  = $random(seed); // Junk on an idle cycle must be ignored
  endtask

  task automatic issue_cycle(input sys_pkg::sys_insn_u w, input logic [xlen-1:0] p,
                             input logic [xlen-1:0] r);
    @(negedge clock);
    check_result();
    issue    = 1'b1;
    insn     = w;
    pc       = p;
    rs1_data = r;
    predict(w, p, r);
    pending = 1'b1;
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    while (pending) begin
      if (waited == drain_limit) abort_run("The last issued instruction never retired");
      idle_cycle();
      waited++;
    end
  endtask

  function automatic sys_pkg::sys_insn_u csr_word(input logic [2:0] f3, input logic [11:0] csr,
                                                  input logic [4:0] src, input logic [4:0] rd);
    sys_pkg::sys_insn_u w;
    w.csr_form.csr    = csr;
    w.csr_form.src    = src;
    w.csr_form.funct3 = f3;
    w.csr_form.rd     = rd;
    w.csr_form.opcode = sys_pkg::opcode_system;
    return w;
  endfunction

  function automatic sys_pkg::sys_insn_u priv_word(input logic [11:0] f12);
    sys_pkg::sys_insn_u w;
    w = '0;
    w.priv_form.funct12 = f12;
    w.priv_form.opcode  = sys_pkg::opcode_system;
    return w;
  endfunction

  function automatic logic [11:0] pick_csr(input int unsigned index);
    case (index)
      0: return sys_pkg::csr_mstatus;
      1: return sys_pkg::csr_mtvec;
      2: return sys_pkg::csr_mepc;
      3: return sys_pkg::csr_mcause;
      4: return sys_pkg::csr_mvendorid;
      5: return sys_pkg::csr_marchid;
      default: return 12'h7c0; // Not held by the unit
    endcase
  endfunction

  task automatic issue_random;
    sys_pkg::sys_insn_u w;
    int unsigned        kind;
    int unsigned        sel;
    logic [4:0]         src;
    logic [4:0]         rd;
    logic [xlen-1:0]    p;
    kind = $unsigned($random(seed)) % 100;
    p    = $random(seed);
    p[1:0] = 2'b00;
    if (kind < 60) begin
      sel = $unsigned($random(seed)) % 6;
      src = $random(seed);
      rd  = $random(seed);
      if (src[4:3] == 2'b00) src = 5'd0; // Zero sources come up often
      w = csr_word((sel < 3) ? 3'(sel + 1) : 3'(sel + 2),
                   pick_csr($unsigned($random(seed)) % 7), src, rd);
    end else if (kind < 75) begin
      w = priv_word(sys_pkg::funct12_ecall);
    end else if (kind < 90) begin
      w = priv_word(sys_pkg::funct12_mret);
    end else begin
      w = $random(seed);
      if (w[0]) begin
        w.priv_form.opcode = sys_pkg::opcode_system;
        w.priv_form.funct3 = {w.priv_form.funct3[2], 2'b00}; // Either 000 or the reserved 100
      end
    end
    issue_cycle(w, p, $random(seed));
  endtask

  initial begin
    int unsigned gap;
    seed     = 90;
    reset    = 1'b1;
    issue    = 1'b0;
    insn     = '0;
    pc       = '0;
    rs1_data = '0;
    pending  = 1'b0;
    model_priv   = sys_pkg::priv_machine;
    model_mpp    = sys_pkg::priv_user;
    model_mie    = 1'b0;
    model_mpie   = 1'b0;
    model_mcause = '0;
    model_mepc   = '0;
    model_mtvec  = mtvec_reset;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_bit("retire", retire, 1'b0);
    check_bit("rd_wen", rd_wen, 1'b0);
    check_bit("redirect", redirect, 1'b0);
    check_bit("illegal", illegal, 1'b0);

    for (int i = 0; i < 7; i++) begin
      issue_cycle(csr_word(3'b010, pick_csr(i), 5'd0, 5'd1), '0, 32'hffff_ffff);
    end
    // Trap entry with MIE set, return to user mode, then a trap taken from user mode
    issue_cycle(csr_word(3'b101, sys_pkg::csr_mstatus, 5'b01000, 5'd2), '0, '0);
    issue_cycle(priv_word(sys_pkg::funct12_ecall), 32'h0000_2000, '0);
    issue_cycle(csr_word(3'b010, sys_pkg::csr_mstatus, 5'd0, 5'd3), '0, '0);
    issue_cycle(csr_word(3'b010, sys_pkg::csr_mcause, 5'd0, 5'd4), '0, '0);
    // MPP is cleared so that MRET drops to user mode
    issue_cycle(csr_word(3'b011, sys_pkg::csr_mstatus, 5'd9, 5'd0), '0, 32'h0000_1800);
    issue_cycle(priv_word(sys_pkg::funct12_mret), '0, '0);
    issue_cycle(csr_word(3'b010, sys_pkg::csr_mstatus, 5'd0, 5'd5), '0, '0);
    issue_cycle(priv_word(sys_pkg::funct12_ecall), 32'h0000_3000, '0);
    issue_cycle(csr_word(3'b010, sys_pkg::csr_mcause, 5'd0, 5'd6), '0, '0);
    issue_cycle(csr_word(3'b001, sys_pkg::csr_mvendorid, 5'd7, 5'd7), '0, 32'h1234_5678);
    issue_cycle(csr_word(3'b010, sys_pkg::csr_mvendorid, 5'd0, 5'd8), '0, '0);
    drain();

    for (int n = 0; n < random_insns; n++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) idle_cycle();
      issue_random();
    end
    drain();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- src/sys_unit_top.sv
`timescale 1ns/10ps

module sys_unit_top #(
  parameter int unsigned     xlen        = 32,
  parameter logic [xlen-1:0] vendor_id   = 'h0000_0a11,
  parameter logic [xlen-1:0] arch_id     = 'h0000_0017,
  parameter logic [xlen-1:0] mtvec_reset = 'h0000_0100
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               issue,
  input  sys_pkg::sys_insn_u insn,
  input  logic [xlen-1:0]    pc,
  input  logic [xlen-1:0]    rs1_data,
  output logic               retire,
  output logic               rd_wen,
  output logic [4:0]         rd_addr,
  output logic [xlen-1:0]    rd_data,
  output logic               redirect,
  output logic [xlen-1:0]    target_pc,
  output logic               illegal
);

  sys_pkg::csr_op_e op;
  logic             use_imm;
  logic [11:0]      csr_addr;
  logic [4:0]       dec_rd_addr;
  logic [4:0]       src_sel;
  logic             is_ecall;
  logic             is_mret;
  logic             dec_illegal;
  logic [xlen-1:0]  csr_rdata;
  logic [xlen-1:0]  mtvec;
  logic [xlen-1:0]  mepc;
  logic [xlen-1:0]  wdata;
  logic             wen;

  sys_decode u_decode (
    .insn(insn), .op(op), .use_imm(use_imm), .csr_addr(csr_addr), .rd_addr(dec_rd_addr),
    .src_sel(src_sel), .is_ecall(is_ecall), .is_mret(is_mret), .illegal(dec_illegal)
  );

  csr_file #(
    .xlen(xlen), .vendor_id(vendor_id), .arch_id(arch_id), .mtvec_reset(mtvec_reset)
  ) u_csr_file (
    .clock(clock), .reset(reset), .issue(issue), .wen(wen), .is_ecall(is_ecall),
    .is_mret(is_mret), .csr_addr(csr_addr), .wdata(wdata), .pc(pc),
    .csr_rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
  );

  csr_alu #(.xlen(xlen)) u_alu (
    .op(op), .use_imm(use_imm), .src_sel(src_sel), .rs1_data(rs1_data),
    .csr_rdata(csr_rdata), .wdata(wdata), .wen(wen)
  );

  sys_retire #(.xlen(xlen)) u_retire (
    .clock(clock), .reset(reset), .issue(issue), .op(op), .rd_addr(dec_rd_addr),
    .csr_rdata(csr_rdata), .is_ecall(is_ecall), .is_mret(is_mret), .illegal(dec_illegal),
    .mtvec(mtvec), .mepc(mepc), .retire(retire), .rd_wen(rd_wen), .rd_addr_q(rd_addr),
    .rd_data(rd_data), .redirect(redirect), .target_pc(target_pc), .illegal_q(illegal)
  );

endmodule

//--- src/sys_retire.sv
`timescale 1ns/10ps

module sys_retire #(
  parameter int unsigned xlen = 32
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              issue,
  input  sys_pkg::csr_op_e  op,
  input  logic [4:0]        rd_addr,
  input  logic [xlen-1:0]   csr_rdata,
  input  logic              is_ecall,
  input  logic              is_mret,
  input  logic              illegal,
  input  logic [xlen-1:0]   mtvec,
  input  logic [xlen-1:0]   mepc,
  output logic              retire,
  output logic              rd_wen,
  output logic [4:0]        rd_addr_q,
  output logic [xlen-1:0]   rd_data,
  output logic              redirect,
  output logic [xlen-1:0]   target_pc,
  output logic              illegal_q
);

  always_ff @(posedge clock) begin
    if (reset) begin
      retire    <= 1'b0;
      rd_wen    <= 1'b0;
      redirect  <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      retire    <= issue;
      rd_wen    <= issue && (op != sys_pkg::csr_op_none) && (rd_addr != 5'd0);
      redirect  <= issue && (is_ecall || is_mret);
      illegal_q <= issue && illegal;
    end
  end

  // mtvec and mepc are sampled before the CSR file updates them on this edge
  always_ff @(posedge clock) begin
    if (issue) begin
      rd_addr_q <= rd_addr;
      rd_data   <= csr_rdata;
      target_pc <= is_ecall ? {mtvec[xlen-1:2], 2'b00} : mepc;
    end
  end

  redirect_retires: assert property (@(posedge clock) disable iff (reset)
    redirect |-> retire);

  write_retires: assert property (@(posedge clock) disable iff (reset)
    rd_wen |-> retire);

endmodule

//--- src/csr_file.sv
`timescale 1ns/10ps

module csr_file #(
  parameter int unsigned     xlen        = 32,
  parameter logic [xlen-1:0] vendor_id   = '0,
  parameter logic [xlen-1:0] arch_id     = '0,
  parameter logic [xlen-1:0] mtvec_reset = '0
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              issue,
  input  logic              wen,
  input  logic              is_ecall,
  input  logic              is_mret,
  input  logic [11:0]       csr_addr,
  input  logic [xlen-1:0]   wdata,
  input  logic [xlen-1:0]   pc,
  output logic [xlen-1:0]   csr_rdata,
  output logic [xlen-1:0]   mtvec,
  output logic [xlen-1:0]   mepc
);

  sys_pkg::priv_e  priv;
  sys_pkg::priv_e  mpp;
  sys_pkg::priv_e  wr_mpp;
  logic            mie;
  logic            mpie;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] ecall_cause;

  // Only MIE, MPIE and MPP exist in mstatus, every other bit reads as zero
  always_comb begin
    mstatus = '0;
    mstatus[sys_pkg::mstatus_mie] = mie;
    mstatus[sys_pkg::mstatus_mpie] = mpie;
    mstatus[sys_pkg::mstatus_mpp_lo +: 2] = mpp;
  end

  always_comb begin
    case (csr_addr)
      sys_pkg::csr_mstatus:   csr_rdata = mstatus;
      sys_pkg::csr_mtvec:     csr_rdata = mtvec;
      sys_pkg::csr_mepc:      csr_rdata = mepc;
      sys_pkg::csr_mcause:    csr_rdata = mcause;
      sys_pkg::csr_mvendorid: csr_rdata = vendor_id;
      sys_pkg::csr_marchid:   csr_rdata = arch_id;
      default:                csr_rdata = '0;
    endcase
  end

  // The reserved MPP encoding 2 is not stored
  always_comb begin
    if (wdata[sys_pkg::mstatus_mpp_lo +: 2] == 2'b10) begin
      wr_mpp = mpp;
    end else begin
      wr_mpp = sys_pkg::priv_e'(wdata[sys_pkg::mstatus_mpp_lo +: 2]);
    end
  end

  always_comb begin
    case (priv)
      sys_pkg::priv_machine:    ecall_cause = xlen'(11);
      sys_pkg::priv_supervisor: ecall_cause = xlen'(9);
      default:                  ecall_cause = xlen'(8);
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      priv   <= sys_pkg::priv_machine;
      mpp    <= sys_pkg::priv_user;
      mie    <= 1'b0;
      mpie   <= 1'b0;
      mcause <= '0;
      mepc   <= '0;
      mtvec  <= mtvec_reset;
    end else if (issue) begin
      if (wen) begin
        case (csr_addr)
          sys_pkg::csr_mstatus: begin
            mie  <= wdata[sys_pkg::mstatus_mie];
            mpie <= wdata[sys_pkg::mstatus_mpie];
            mpp  <= wr_mpp;
          end
          sys_pkg::csr_mtvec:  mtvec  <= wdata;
          sys_pkg::csr_mepc:   mepc   <= wdata;
          sys_pkg::csr_mcause: mcause <= wdata;
          default: ; // Read-only and unknown CSRs drop the write
        endcase
      end
      if (is_ecall) begin
        mcause <= ecall_cause;
        mepc   <= pc;
        mpie   <= mie;
        mie    <= 1'b0;
        mpp    <= priv;
        priv   <= sys_pkg::priv_machine;
      end
      if (is_mret) begin
        priv <= mpp;
        mie  <= mpie;
        mpie <= 1'b1;
        mpp  <= sys_pkg::priv_user;
      end
    end
  end

  // The decoder and the ALU together must never ask for two updates at once
  one_update: assert property (@(posedge clock) disable iff (reset)
    issue |-> $onehot0({wen, is_ecall, is_mret}));

endmodule

//--- src/csr_alu.sv
`timescale 1ns/10ps

module csr_alu #(
  parameter int unsigned xlen = 32
) (
  input  sys_pkg::csr_op_e  op,
  input  logic              use_imm,
  input  logic [4:0]        src_sel,
  input  logic [xlen-1:0]   rs1_data,
  input  logic [xlen-1:0]   csr_rdata,
  output logic [xlen-1:0]   wdata,
  output logic              wen
);

  logic [xlen-1:0] operand;

  assign operand = use_imm ? {{(xlen-5){1'b0}}, src_sel} : rs1_data;

  always_comb begin
    case (op)
      sys_pkg::csr_op_write: wdata = operand;
      sys_pkg::csr_op_set:   wdata = csr_rdata | operand;
      sys_pkg::csr_op_clear: wdata = csr_rdata & ~operand;
      default:               wdata = csr_rdata;
    endcase
  end

  // Set and clear with x0 or zimm 0 are pure reads
  always_comb begin
    case (op)
      sys_pkg::csr_op_write: wen = 1'b1;
      sys_pkg::csr_op_set,
      sys_pkg::csr_op_clear: wen = (src_sel != 5'd0);
      default:               wen = 1'b0;
    endcase
  end

endmodule

//--- src/sys_decode.sv
`timescale 1ns/10ps

module sys_decode (
  input  sys_pkg::sys_insn_u insn,
  output sys_pkg::csr_op_e   op,
  output logic               use_imm,
  output logic [11:0]        csr_addr,
  output logic [4:0]         rd_addr,
  output logic [4:0]         src_sel,
  output logic               is_ecall,
  output logic               is_mret,
  output logic               illegal
);

  // Fields are passed on as they are; op and the flags gate their use
  assign csr_addr = insn.csr_form.csr;
  assign rd_addr  = insn.csr_form.rd;
  assign src_sel  = insn.csr_form.src;

  always_comb begin
    op       = sys_pkg::csr_op_none;
    use_imm  = 1'b0;
    is_ecall = 1'b0;
    is_mret  = 1'b0;
    illegal  = 1'b0;
    if (insn.csr_form.opcode != sys_pkg::opcode_system) begin
      illegal = 1'b1;
    end else begin
      case (insn.csr_form.funct3)
        sys_pkg::funct3_priv: begin
          // Only here does the word carry a funct12
          if (insn.priv_form.funct12 == sys_pkg::funct12_ecall) begin
            is_ecall = 1'b1;
          end else if (insn.priv_form.funct12 == sys_pkg::funct12_mret) begin
            is_mret = 1'b1;
          end else begin
            illegal = 1'b1;
          end
        end
        sys_pkg::funct3_csrrw:  op = sys_pkg::csr_op_write;
        sys_pkg::funct3_csrrs:  op = sys_pkg::csr_op_set;
        sys_pkg::funct3_csrrc:  op = sys_pkg::csr_op_clear;
        sys_pkg::funct3_csrrwi: begin
          op      = sys_pkg::csr_op_write;
          use_imm = 1'b1;
        end
        sys_pkg::funct3_csrrsi: begin
          op      = sys_pkg::csr_op_set;
          use_imm = 1'b1;
        end
        sys_pkg::funct3_csrrci: begin
          op      = sys_pkg::csr_op_clear;
          use_imm = 1'b1;
        end
        default: illegal = 1'b1; // funct3 100 is reserved
      endcase
    end
  end

endmodule

//--- src/sys_pkg.sv
package sys_pkg;

  // One SYSTEM word, read either as a CSR access or as a privileged op
  typedef union packed {
    struct packed {
      logic [11:0] csr;
      logic [4:0]  src;     // rs1 index, or zimm for the immediate forms
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csr_form;
    struct packed {
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } priv_form;
  } sys_insn_u;

  typedef enum logic [1:0] {
    csr_op_none  = 2'd0,
    csr_op_write = 2'd1,
    csr_op_set   = 2'd2,
    csr_op_clear = 2'd3
  } csr_op_e;

  typedef enum logic [1:0] {
    priv_user       = 2'd0,
    priv_supervisor = 2'd1,
    priv_machine    = 2'd3
  } priv_e;

  localparam logic [11:0] csr_mstatus   = 12'h300;
  localparam logic [11:0] csr_mtvec     = 12'h305;
  localparam logic [11:0] csr_mepc      = 12'h341;
  localparam logic [11:0] csr_mcause    = 12'h342;
  localparam logic [11:0] csr_mvendorid = 12'hf11;
  localparam logic [11:0] csr_marchid   = 12'hf12;

  localparam int unsigned mstatus_mie    = 3;
  localparam int unsigned mstatus_mpie   = 7;
  localparam int unsigned mstatus_mpp_lo = 11; // MPP is bits 12:11

  localparam logic [6:0]  opcode_system = 7'b1110011;
  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_mret  = 12'h302;

  // funct3 field of the SYSTEM opcode
  localparam logic [2:0] funct3_priv   = 3'b000;
  localparam logic [2:0] funct3_csrrw  = 3'b001;
  localparam logic [2:0] funct3_csrrs  = 3'b010;
  localparam logic [2:0] funct3_csrrc  = 3'b011;
  localparam logic [2:0] funct3_csrrwi = 3'b101;
  localparam logic [2:0] funct3_csrrsi = 3'b110;
  localparam logic [2:0] funct3_csrrci = 3'b111;

endpackage
